// File: source/bringup_macros.svh
// Bring-up system parameters
// Widths, address map, memory sizes and ROM image

`ifndef BRINGUP_MACROS_SVH
`define BRINGUP_MACROS_SVH

// Bus widths of one word per transfer
`define BRINGUP_ADDR_W 16
`define BRINGUP_DATA_W 32

// Region decode on the top address nibble
`define BRINGUP_REGION_MASK 16'hF000
`define BRINGUP_ROM_BASE    16'hF000
`define BRINGUP_MMIO_BASE   16'hE000

// Memory sizes in words
`define BRINGUP_ROM_WORDS 16
`define BRINGUP_RAM_WORDS 256

// First four ROM words copied to RAM after reset
`define BRINGUP_ROM_WORD0 32'hC0DE_0001
`define BRINGUP_ROM_WORD1 32'h8BAD_F00D
`define BRINGUP_ROM_WORD2 32'h1234_5678
`define BRINGUP_ROM_WORD3 32'hFEED_FACE

// Constant read back from the ID register
`define BRINGUP_ID_VALUE 32'h4252_0001

// Words moved by the init sequencer
`define BRINGUP_COPY_WORDS 4

`endif

// File: source/bringup_bus_pkg.sv
// Bring-up bus types

`include "bringup_macros.svh"

package bringup_bus_pkg;

  // One bus address and one data word
  typedef logic [`BRINGUP_ADDR_W-1:0] addr_t;
  typedef logic [`BRINGUP_DATA_W-1:0] data_t;

  // Master index used by the arbiter
  typedef logic [0:0] master_sel_t;

  localparam master_sel_t MASTER_SEQ  = 1'b0;
  localparam master_sel_t MASTER_HOST = 1'b1;

endpackage : bringup_bus_pkg

// File: source/bringup_memmap_pkg.sv
// Bring-up memory map types

package bringup_memmap_pkg;

  // Slave selected by the region decode
  typedef enum logic [1:0] {
    SLAVE_ROM,
    SLAVE_RAM,
    SLAVE_MMIO
  } slave_sel_e;

  // MMIO registers indexed by byte offset over four
  typedef enum logic [1:0] {
    REG_SIGNATURE = 2'd0,
    REG_POWEROFF  = 2'd1,
    REG_SCRATCH   = 2'd2,
    REG_ID        = 2'd3
  } mmio_reg_e;

endpackage : bringup_memmap_pkg

// File: source/fabric_if.sv
// Fabric request/response link

interface fabric_if;

  // Level request on the master side, one-cycle strobe on the slave side
  logic                   req;
  logic                   we;
  bringup_bus_pkg::addr_t addr;
  bringup_bus_pkg::data_t wdata;

  // Response with rdata valid only while done is high
  bringup_bus_pkg::data_t rdata;
  logic                   done;

  modport master (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata, done
  );

endinterface : fabric_if

// File: source/fabric_arbiter.sv
// Two-master fabric arbiter
// Round-robin grant, region decode and response routing

`include "bringup_macros.svh"

module fabric_arbiter (
  input logic      clk,
  input logic      rst_n,
  fabric_if.slave  m_seq,
  fabric_if.slave  m_host,
  fabric_if.master s_rom,
  fabric_if.master s_ram,
  fabric_if.master s_mmio
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ISSUE,
    ARB_WAIT
  } arb_state_e;

  arb_state_e                     state_q;
  bringup_bus_pkg::master_sel_t   owner_q;
  bringup_bus_pkg::master_sel_t   last_q;
  bringup_bus_pkg::master_sel_t   grant;
  bringup_memmap_pkg::slave_sel_e sel_q;
  bringup_memmap_pkg::slave_sel_e sel_d;
  bringup_bus_pkg::addr_t         grant_addr;
  logic                           any_req;

  // Owner request, held stable by the master for the whole transfer
  logic                   own_we;
  bringup_bus_pkg::addr_t own_addr;
  bringup_bus_pkg::data_t own_wdata;

  // Response of the selected slave
  bringup_bus_pkg::data_t slv_rdata;
  logic                   slv_done;
  logic                   resp_done;

  // --------------------------------------------------------------------------
  // Grant and decode
  // --------------------------------------------------------------------------
  always_comb begin
    any_req = m_seq.req || m_host.req;
    // With both asking the one not served last wins
    if (m_seq.req && m_host.req) begin
      grant = ~last_q;
    end else if (m_host.req) begin
      grant = bringup_bus_pkg::MASTER_HOST;
    end else begin
      grant = bringup_bus_pkg::MASTER_SEQ;
    end
    grant_addr = (grant == bringup_bus_pkg::MASTER_HOST) ? m_host.addr : m_seq.addr;
    if ((grant_addr & `BRINGUP_REGION_MASK) == `BRINGUP_ROM_BASE) begin
      sel_d = bringup_memmap_pkg::SLAVE_ROM;
    end else if ((grant_addr & `BRINGUP_REGION_MASK) == `BRINGUP_MMIO_BASE) begin
      sel_d = bringup_memmap_pkg::SLAVE_MMIO;
    end else begin
      sel_d = bringup_memmap_pkg::SLAVE_RAM;
    end
  end

  // --------------------------------------------------------------------------
  // Request and response muxing
  // --------------------------------------------------------------------------
  always_comb begin
    own_we    = (owner_q == bringup_bus_pkg::MASTER_HOST) ? m_host.we : m_seq.we;
    own_addr  = (owner_q == bringup_bus_pkg::MASTER_HOST) ? m_host.addr : m_seq.addr;
    own_wdata = (owner_q == bringup_bus_pkg::MASTER_HOST) ? m_host.wdata : m_seq.wdata;
    slv_rdata = s_ram.rdata;
    slv_done  = s_ram.done;
    unique case (sel_q)
      bringup_memmap_pkg::SLAVE_ROM: begin
        slv_rdata = s_rom.rdata;
        slv_done  = s_rom.done;
      end
      bringup_memmap_pkg::SLAVE_MMIO: begin
        slv_rdata = s_mmio.rdata;
        slv_done  = s_mmio.done;
      end
      default: begin
      end
    endcase
  end

  assign resp_done = (state_q != ARB_IDLE) && slv_done;

  // Strobe lasts the single ISSUE cycle
  assign s_rom.req    = (state_q == ARB_ISSUE) && (sel_q == bringup_memmap_pkg::SLAVE_ROM);
  assign s_ram.req    = (state_q == ARB_ISSUE) && (sel_q == bringup_memmap_pkg::SLAVE_RAM);
  assign s_mmio.req   = (state_q == ARB_ISSUE) && (sel_q == bringup_memmap_pkg::SLAVE_MMIO);
  assign s_rom.we     = own_we;
  assign s_ram.we     = own_we;
  assign s_mmio.we    = own_we;
  assign s_rom.addr   = own_addr;
  assign s_ram.addr   = own_addr;
  assign s_mmio.addr  = own_addr;
  assign s_rom.wdata  = own_wdata;
  assign s_ram.wdata  = own_wdata;
  assign s_mmio.wdata = own_wdata;

  // Only the owner sees done
  assign m_seq.rdata  = slv_rdata;
  assign m_host.rdata = slv_rdata;
  assign m_seq.done   = resp_done && (owner_q == bringup_bus_pkg::MASTER_SEQ);
  assign m_host.done  = resp_done && (owner_q == bringup_bus_pkg::MASTER_HOST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
      owner_q <= bringup_bus_pkg::MASTER_SEQ;
      last_q  <= bringup_bus_pkg::MASTER_HOST;
      sel_q   <= bringup_memmap_pkg::SLAVE_RAM;
    end else begin
      unique case (state_q)
        ARB_IDLE: begin
          if (any_req) begin
            owner_q <= grant;
            sel_q   <= sel_d;
            state_q <= ARB_ISSUE;
          end
        end
        ARB_ISSUE, ARB_WAIT: begin
          // MMIO answers inside the ISSUE cycle
          if (slv_done) begin
            last_q  <= owner_q;
            state_q <= ARB_IDLE;
          end else begin
            state_q <= ARB_WAIT;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule : fabric_arbiter

// File: source/init_sequencer.sv
// Post-reset init sequencer
// Copies the ROM head to RAM and posts its sum as signature

`include "bringup_macros.svh"

module init_sequencer (
  input  logic     clk,
  input  logic     rst_n,
  fabric_if.master bus,
  output logic     init_done
);

  localparam int CNT_W = $clog2(`BRINGUP_COPY_WORDS);

  typedef enum logic [1:0] {
    SEQ_READ,
    SEQ_WRITE,
    SEQ_SIGN,
    SEQ_DONE
  } seq_state_e;

  seq_state_e             state_q;
  logic                   req_q;
  logic [CNT_W-1:0]       cnt_q;
  bringup_bus_pkg::data_t sum_q;
  bringup_bus_pkg::data_t word_q;
  logic                   last_word;

  assign last_word = (cnt_q == CNT_W'(`BRINGUP_COPY_WORDS - 1));

  // Request fields follow the state and stay put until done
  always_comb begin
    bus.req   = req_q;
    bus.we    = 1'b0;
    bus.addr  = '0;
    bus.wdata = word_q;
    unique case (state_q)
      SEQ_READ: begin
        bus.addr = bringup_bus_pkg::addr_t'(`BRINGUP_ROM_BASE)
                 + bringup_bus_pkg::addr_t'({cnt_q, 2'b00});
      end
      SEQ_WRITE: begin
        bus.we   = 1'b1;
        bus.addr = bringup_bus_pkg::addr_t'({cnt_q, 2'b00});
      end
      SEQ_SIGN: begin
        bus.we    = 1'b1;
        bus.addr  = bringup_bus_pkg::addr_t'(`BRINGUP_MMIO_BASE)
                  + bringup_bus_pkg::addr_t'({bringup_memmap_pkg::REG_SIGNATURE, 2'b00});
        bus.wdata = sum_q;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= SEQ_READ;
      req_q     <= 1'b0;
      cnt_q     <= '0;
      sum_q     <= '0;
      init_done <= 1'b0;
    end else if (!req_q) begin
      // One idle cycle between transfers
      if (state_q != SEQ_DONE) req_q <= 1'b1;
    end else if (bus.done) begin
      req_q <= 1'b0;
      unique case (state_q)
        SEQ_READ: begin
          sum_q   <= sum_q + bus.rdata;
          state_q <= SEQ_WRITE;
        end
        SEQ_WRITE: begin
          cnt_q   <= cnt_q + 1'b1;
          state_q <= last_word ? SEQ_SIGN : SEQ_READ;
        end
        SEQ_SIGN: begin
          state_q   <= SEQ_DONE;
          init_done <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // ROM word held for the following RAM write
  always_ff @(posedge clk) begin
    if (req_q && bus.done && (state_q == SEQ_READ)) word_q <= bus.rdata;
  end

endmodule : init_sequencer

// File: source/boot_rom.sv
// Boot ROM with built-in image

`include "bringup_macros.svh"

module boot_rom (
  input logic     clk,
  input logic     rst_n,
  fabric_if.slave bus
);

  localparam int IDX_W = $clog2(`BRINGUP_ROM_WORDS);

  typedef bringup_bus_pkg::data_t rom_image_t [`BRINGUP_ROM_WORDS];

  // Words past the copied head hold their own index
  function automatic rom_image_t build_image();
    rom_image_t img;
    for (int i = 0; i < `BRINGUP_ROM_WORDS; i++) begin
      img[i] = bringup_bus_pkg::data_t'(i);
    end
    img[0] = `BRINGUP_ROM_WORD0;
    img[1] = `BRINGUP_ROM_WORD1;
    img[2] = `BRINGUP_ROM_WORD2;
    img[3] = `BRINGUP_ROM_WORD3;
    return img;
  endfunction

  localparam rom_image_t ROM_IMAGE = build_image();

  logic                   done_q;
  bringup_bus_pkg::data_t rdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) done_q <= 1'b0;
    else done_q <= bus.req;
  end

  // Writes get done but leave nothing behind
  always_ff @(posedge clk) begin
    if (bus.req && !bus.we) rdata_q <= ROM_IMAGE[bus.addr[IDX_W+1:2]];
  end

  assign bus.done  = done_q;
  assign bus.rdata = rdata_q;

endmodule : boot_rom

// File: source/word_sram.sv
// Word-wide SRAM

`include "bringup_macros.svh"

module word_sram (
  input logic     clk,
  input logic     rst_n,
  fabric_if.slave bus
);

  localparam int IDX_W = $clog2(`BRINGUP_RAM_WORDS);

  bringup_bus_pkg::data_t mem [`BRINGUP_RAM_WORDS];
  bringup_bus_pkg::data_t rdata_q;
  logic                   done_q;
  logic [IDX_W-1:0]       idx;

  // Upper address bits wrap onto the array
  assign idx = bus.addr[IDX_W+1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) done_q <= 1'b0;
    else done_q <= bus.req;
  end

  always_ff @(posedge clk) begin
    if (bus.req) begin
      if (bus.we) mem[idx] <= bus.wdata;
      else rdata_q <= mem[idx];
    end
  end

  assign bus.done  = done_q;
  assign bus.rdata = rdata_q;

endmodule : word_sram

// File: source/mmio_regs.sv
// MMIO register block

`include "bringup_macros.svh"

module mmio_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  fabric_if.slave                bus,
  output bringup_bus_pkg::data_t signature,
  output logic                   poweroff
);

  bringup_memmap_pkg::mmio_reg_e reg_sel;
  bringup_bus_pkg::data_t        scratch_q;
  logic                          wr;

  assign reg_sel = bringup_memmap_pkg::mmio_reg_e'(bus.addr[3:2]);
  assign wr      = bus.req && bus.we;

  // Zero-latency slave
  assign bus.done = bus.req;

  always_comb begin
    unique case (reg_sel)
      bringup_memmap_pkg::REG_SIGNATURE: bus.rdata = signature;
      bringup_memmap_pkg::REG_POWEROFF:  bus.rdata = {{(`BRINGUP_DATA_W-1){1'b0}}, poweroff};
      bringup_memmap_pkg::REG_SCRATCH:   bus.rdata = scratch_q;
      default:                           bus.rdata = `BRINGUP_ID_VALUE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signature <= '0;
      poweroff  <= 1'b0;
    end else if (wr) begin
      if (reg_sel == bringup_memmap_pkg::REG_SIGNATURE) signature <= bus.wdata;
      // Sticky until reset
      if (reg_sel == bringup_memmap_pkg::REG_POWEROFF && bus.wdata[0]) poweroff <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && reg_sel == bringup_memmap_pkg::REG_SCRATCH) scratch_q <= bus.wdata;
  end

endmodule : mmio_regs

// File: source/bringup_top.sv
// Bring-up system top

module bringup_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   host_req,
  input  logic                   host_we,
  input  bringup_bus_pkg::addr_t host_addr,
  input  bringup_bus_pkg::data_t host_wdata,
  output bringup_bus_pkg::data_t host_rdata,
  output logic                   host_done,
  output logic                   init_done,
  output bringup_bus_pkg::data_t signature,
  output logic                   poweroff
);

  fabric_if seq_link ();
  fabric_if host_link ();
  fabric_if rom_link ();
  fabric_if ram_link ();
  fabric_if mmio_link ();

  // Host master comes straight from the pins
  assign host_link.req   = host_req;
  assign host_link.we    = host_we;
  assign host_link.addr  = host_addr;
  assign host_link.wdata = host_wdata;
  assign host_rdata      = host_link.rdata;
  assign host_done       = host_link.done;

  fabric_arbiter u_fabric (
    .clk   (clk),
    .rst_n (rst_n),
    .m_seq (seq_link),
    .m_host(host_link),
    .s_rom (rom_link),
    .s_ram (ram_link),
    .s_mmio(mmio_link)
  );

  init_sequencer u_init (.clk(clk), .rst_n(rst_n), .bus(seq_link), .init_done(init_done));

  boot_rom u_rom (.clk(clk), .rst_n(rst_n), .bus(rom_link));

  word_sram u_ram (.clk(clk), .rst_n(rst_n), .bus(ram_link));

  mmio_regs u_mmio (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus      (mmio_link),
    .signature(signature),
    .poweroff (poweroff)
  );

endmodule : bringup_top

// File: sim/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

// File: sim/bringup_properties.sv
// Bring-up system protocol assertions

module bringup_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   host_req,
  input logic                   host_done,
  input logic                   init_done,
  input logic                   poweroff,
  input bringup_bus_pkg::data_t signature,
  fabric_if                     rom_bus,
  fabric_if                     ram_bus,
  fabric_if                     mmio_bus
);

  int unsigned fail_count = 0;
  logic        mmio_written;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) mmio_written <= 1'b0;
    else if (mmio_bus.req && mmio_bus.we) mmio_written <= 1'b1;
  end

  // ---------------------------------------------------------------------------
  // Slave done follows its strobe in the same or the next cycle
  // ---------------------------------------------------------------------------
  rom_done_a: assert property (@(posedge clk) disable iff (!rst_n)
    rom_bus.done |-> (rom_bus.req || $past(rom_bus.req)))
    else begin
      fail_count++;
      $error("ROM done without a strobe");
    end

  ram_done_a: assert property (@(posedge clk) disable iff (!rst_n)
    ram_bus.done |-> (ram_bus.req || $past(ram_bus.req)))
    else begin
      fail_count++;
      $error("RAM done without a strobe");
    end

  mmio_done_a: assert property (@(posedge clk) disable iff (!rst_n)
    mmio_bus.done |-> (mmio_bus.req || $past(mmio_bus.req)))
    else begin
      fail_count++;
      $error("MMIO done without a strobe");
    end

  host_done_a: assert property (@(posedge clk) disable iff (!rst_n)
    host_done |-> host_req)
    else begin
      fail_count++;
      $error("host_done while host_req is low");
    end

  // Sticky outputs
  poweroff_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(poweroff))
    else begin
      fail_count++;
      $error("poweroff fell outside reset");
    end

  init_done_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(init_done))
    else begin
      fail_count++;
      $error("init_done fell outside reset");
    end

  signature_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
    !mmio_written |-> (signature == '0))
    else begin
      fail_count++;
      $error("signature changed before any MMIO write");
    end

endmodule : bringup_properties

// File: sim/bringup_tb.sv
// Bring-up system testbench

`include "bringup_macros.svh"

module bringup_tb;

  localparam int DONE_TIMEOUT = 50;
  localparam int INIT_TIMEOUT = 1000;
  localparam int RESET_TIMEOUT = 20;
  localparam int RAM_WRITES = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   host_req;
  logic                   host_we;
  bringup_bus_pkg::addr_t host_addr;
  bringup_bus_pkg::data_t host_wdata;
  bringup_bus_pkg::data_t host_rdata;
  logic                   host_done;
  logic                   init_done;
  bringup_bus_pkg::data_t signature;
  logic                   poweroff;

  int unsigned mismatch_count = 0;
  int unsigned timeout_count = 0;

  // Last value written per RAM word index
  bringup_bus_pkg::data_t ram_model [int];
  bringup_bus_pkg::addr_t wr_addr [RAM_WRITES];

  tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

  bringup_top bringup_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_req  (host_req),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(host_rdata),
    .host_done (host_done),
    .init_done (init_done),
    .signature (signature),
    .poweroff  (poweroff)
  );

  bind bringup_top bringup_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_done(host_done),
    .init_done(init_done),
    .poweroff (poweroff),
    .signature(signature),
    .rom_bus  (rom_link),
    .ram_bus  (ram_link),
    .mmio_bus (mmio_link)
  );

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  task automatic check_word(input bringup_bus_pkg::data_t actual,
                            input bringup_bus_pkg::data_t expected, input string what);
    assert (actual === expected)
    else begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // Level request held until done and dropped in the following cycle
  task automatic host_access(input logic we, input bringup_bus_pkg::addr_t addr,
                             input bringup_bus_pkg::data_t wdata,
                             output bringup_bus_pkg::data_t rdata);
    int  cycles;
    bit  seen;
    cycles = 0;
    seen = 1'b0;
    rdata = '0;
    @(negedge clk);
    host_req = 1'b1;
    host_we = we;
    host_addr = addr;
    host_wdata = wdata;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (host_done) begin
        seen = 1'b1;
        rdata = host_rdata;
      end
    end
    if (!seen) begin
      timeout_count++;
      $display("Host access to address %h got no done within %0d cycles", addr, DONE_TIMEOUT);
    end
    @(negedge clk);
    host_req = 1'b0;
    host_we = 1'b0;
  endtask

  task automatic sync_reset();
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      timeout_count++;
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic await_init();
    int cycles;
    cycles = 0;
    while (!init_done && cycles < INIT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!init_done) begin
      timeout_count++;
      $display("init_done did not rise within %0d cycles", INIT_TIMEOUT);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  initial begin
    bringup_bus_pkg::data_t rd;
    bringup_bus_pkg::data_t wv;
    bringup_bus_pkg::data_t sum;
    bringup_bus_pkg::data_t rom_head [4];
    int                     idx;
    int unsigned            prop_fails;

    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    void'($urandom(96));

    rom_head[0] = `BRINGUP_ROM_WORD0;
    rom_head[1] = `BRINGUP_ROM_WORD1;
    rom_head[2] = `BRINGUP_ROM_WORD2;
    rom_head[3] = `BRINGUP_ROM_WORD3;
    sum = rom_head[0] + rom_head[1] + rom_head[2] + rom_head[3];

    sync_reset();

    // Host competes with the running sequencer
    host_access(1'b0, `BRINGUP_MMIO_BASE + 16'h000C, '0, rd);
    check_word(rd, `BRINGUP_ID_VALUE, "ID read during init");

    await_init();
    check_word(signature, sum, "signature after init");

    // RAM copy and ROM image
    for (int i = 0; i < 4; i++) begin
      host_access(1'b0, bringup_bus_pkg::addr_t'(i * 4), '0, rd);
      check_word(rd, rom_head[i], $sformatf("RAM word %0d", i));
      host_access(1'b0, `BRINGUP_ROM_BASE + bringup_bus_pkg::addr_t'(i * 4), '0, rd);
      check_word(rd, rom_head[i], $sformatf("ROM word %0d", i));
    end
    host_access(1'b0, `BRINGUP_ROM_BASE + 16'h001C, '0, rd);
    check_word(rd, 32'd7, "ROM word 7");

    // Random RAM writes followed by read-back against the model
    for (int i = 0; i < RAM_WRITES; i++) begin
      wr_addr[i] = bringup_bus_pkg::addr_t'($urandom_range(16'hDFFF, 0)) & 16'hFFFC;
      wv = $urandom();
      idx = (wr_addr[i] >> 2) % `BRINGUP_RAM_WORDS;
      ram_model[idx] = wv;
      host_access(1'b1, wr_addr[i], wv, rd);
    end
    for (int i = 0; i < RAM_WRITES; i++) begin
      idx = (wr_addr[i] >> 2) % `BRINGUP_RAM_WORDS;
      host_access(1'b0, wr_addr[i], '0, rd);
      check_word(rd, ram_model[idx], $sformatf("RAM read-back at %h", wr_addr[i]));
    end

    host_access(1'b1, `BRINGUP_ROM_BASE + 16'h0008, $urandom(), rd);
    host_access(1'b0, `BRINGUP_ROM_BASE + 16'h0008, '0, rd);
    check_word(rd, rom_head[2], "ROM word 2 after write");

    // MMIO registers
    wv = $urandom();
    host_access(1'b1, `BRINGUP_MMIO_BASE + 16'h0008, wv, rd);
    host_access(1'b0, `BRINGUP_MMIO_BASE + 16'h0008, '0, rd);
    check_word(rd, wv, "scratch read-back");
    host_access(1'b1, `BRINGUP_MMIO_BASE + 16'h000C, $urandom(), rd);
    host_access(1'b0, `BRINGUP_MMIO_BASE + 16'h000C, '0, rd);
    check_word(rd, `BRINGUP_ID_VALUE, "ID after write");
    wv = $urandom();
    host_access(1'b1, `BRINGUP_MMIO_BASE, wv, rd);
    check_word(signature, wv, "signature after host write");

    // Power-off latch
    host_access(1'b1, `BRINGUP_MMIO_BASE + 16'h0004, 32'd0, rd);
    check_word(bringup_bus_pkg::data_t'(poweroff), 32'd0, "poweroff after writing 0");
    host_access(1'b1, `BRINGUP_MMIO_BASE + 16'h0004, 32'd1, rd);
    check_word(bringup_bus_pkg::data_t'(poweroff), 32'd1, "poweroff after writing 1");
    host_access(1'b1, `BRINGUP_MMIO_BASE + 16'h0004, 32'd0, rd);
    check_word(bringup_bus_pkg::data_t'(poweroff), 32'd1, "poweroff held high");

    repeat (2) @(negedge clk);
    prop_fails = bringup_top_i.u_props.fail_count;
    $display("Mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             mismatch_count, timeout_count, prop_fails);
    if (mismatch_count == 0 && timeout_count == 0 && prop_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : bringup_tb

// File: project.f
+incdir+source
source/bringup_bus_pkg.sv
source/bringup_memmap_pkg.sv
source/fabric_if.sv
source/fabric_arbiter.sv
source/init_sequencer.sv
source/boot_rom.sv
source/word_sram.sv
source/mmio_regs.sv
source/bringup_top.sv
sim/tb_clock_gen.sv
sim/bringup_properties.sv
sim/bringup_tb.sv
